/* all.f */
lsuPkg.sv
cacheTagTable.sv
cacheDataArray.sv
lsuPipeline.sv
missHandler.sv
loadStoreUnit.sv
lsuHandshake_assert.sv
tbLoadStoreUnit.sv

/* tbLoadStoreUnit.sv */
// testbench for the load/store unit with a memory controller model and a shadow cache model
`timescale 1ns/1ns
`default_nettype none

module tbLoadStoreUnit;
    import lsuPkg::*;

    localparam int memSize = 256;
    localparam int numOps = 22;
    localparam int numFlushes = 1;
    // one extra op slot covers reset and the initial invalidation
    localparam int cycleLimit = 40 * (numOps + 1) + 200 * numFlushes;

    logic clk;
    logic rst;
    lsuOp_t op;
    logic stall;
    lsuResult_t result;
    logic flush;
    logic busy;
    memReq_t memReq;
    logic req;
    logic ack;
    lineData_t rline;

    // controller memory, and the reference view with completed stores merged in
    logic [31:0] memWords [memSize];
    logic [31:0] refMem [memSize];
    // shadow of the cache contents, line address per set and way
    logic [31:0] shAddr [numSets][numWays];
    logic shValid [numSets][numWays];
    logic shDirty [numSets][numWays];
    int victimCnt;
    memReq_t reqLog [$];
    memReq_t expMiss;
    lsuOp_t curOp;
    logic lastFail;
    int resultsSeen;
    int cycles = 0;
    string testName;

    loadStoreUnit dut0 (
        .clk(clk), .rst(rst), .op(op), .stall(stall), .result(result),
        .flush(flush), .busy(busy), .memReq(memReq), .req(req), .ack(ack), .rline(rline)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic failRun(string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycleLimit)
            failRun("timeout: the run went past its cycle limit");
    end

    // fill pattern mixes every address bit
    function automatic logic [31:0] fillWord(int idx);
        logic [31:0] byteAddr;
        byteAddr = idx * 4;
        return (byteAddr * 32'h9e3779b1) ^ {byteAddr[15:0], ~byteAddr[15:0]};
    endfunction

    // expected load word: model memory plus all completed stores
    function automatic logic [31:0] refWord(logic [31:0] addr);
        return refMem[addr[9:2]];
    endfunction

    function automatic lineData_t refLine(logic [31:0] lineAddr);
        lineData_t line;
        for (int w = 0; w < lineWords; w++)
            line[w*32 +: 32] = refWord(lineAddr + w * 4);
        return line;
    endfunction

    // way holding the line in the shadow, -1 on a miss
    function automatic int shadowWay(cacheAddr_t addr);
        int way;
        way = -1;
        for (int w = 0; w < numWays; w++) begin
            if (shValid[addr.split.index][w]
                    && shAddr[addr.split.index][w][31:offsetBits] == addr.raw[31:offsetBits])
                way = w;
        end
        return way;
    endfunction

    task automatic checkResult(string name, lsuResult_t exp, lsuResult_t act);
        logic bad;
        bad = act.valid !== exp.valid || act.fail !== exp.fail || act.isStore !== exp.isStore
            || act.addr !== exp.addr || (!exp.fail && act.data !== exp.data);
        if (bad)
            failRun($sformatf("** Error %s: expected %h, actual %h", name, exp, act));
    endtask

    // fields that a command does not use are not compared
    task automatic checkMemReq(string name, memReq_t exp, memReq_t act);
        logic bad;
        bad = act.cmd !== exp.cmd;
        if (exp.cmd != MEMC_WRITEBACK && act.readAddr !== exp.readAddr)
            bad = 1'b1;
        if ((exp.cmd == MEMC_REPLACE || exp.cmd == MEMC_WRITEBACK)
                && (act.writeAddr !== exp.writeAddr || act.wline !== exp.wline))
            bad = 1'b1;
        if (bad)
            failRun($sformatf("** Error %s: expected %h, actual %h", name, exp, act));
    endtask

    // memory controller: four-phase handshake after a random delay of 1 to 8 cycles
    always begin : memModel
        memReq_t cur;
        int delay;
        @(negedge clk);
        if (!rst && req === 1'b1 && ack === 1'b0) begin
            cur = memReq;
            reqLog.push_back(cur);
            delay = $urandom_range(8, 1);
            repeat (delay - 1)
                @(negedge clk);
            @(posedge clk);
            if (cur.cmd == MEMC_REPLACE || cur.cmd == MEMC_WRITEBACK) begin
                for (int w = 0; w < lineWords; w++)
                    memWords[cur.writeAddr[9:2] + w] = cur.wline[w*32 +: 32];
            end
            for (int w = 0; w < lineWords; w++)
                rline[w*32 +: 32] <= memWords[cur.readAddr[9:2] + w];
            ack <= 1'b1;
            while (req !== 1'b0)
                @(negedge clk);
            @(posedge clk);
            ack <= 1'b0;
        end
    end

    // compares every result with the reference and updates the shadow
    always @(negedge clk) begin : compareResults
        lsuResult_t exp;
        int way;
        int set;
        if (!rst && result.valid === 1'b1) begin
            set = curOp.addr.split.index;
            way = shadowWay(curOp.addr);
            exp.valid = 1'b1;
            exp.fail = (way < 0);
            exp.isStore = curOp.isStore;
            exp.addr = curOp.addr;
            exp.data = curOp.isStore ? curOp.wdata : refWord(curOp.addr.raw);
            checkResult(testName, exp, result);
            if (exp.fail) begin
                // the miss refills the round-robin victim
                if (shValid[set][victimCnt] && shDirty[set][victimCnt])
                    expMiss.cmd = MEMC_REPLACE;
                else
                    expMiss.cmd = MEMC_FILL;
                expMiss.readAddr = {curOp.addr.raw[31:offsetBits], {offsetBits{1'b0}}};
                expMiss.writeAddr = shAddr[set][victimCnt];
                expMiss.wline = refLine(shAddr[set][victimCnt]);
                shAddr[set][victimCnt] = expMiss.readAddr;
                shValid[set][victimCnt] = 1'b1;
                shDirty[set][victimCnt] = 1'b0;
                victimCnt = 1 - victimCnt;
            end else if (curOp.isStore) begin
                for (int b = 0; b < 4; b++) begin
                    if (curOp.wmask[b])
                        refMem[curOp.addr.raw[9:2]][b*8 +: 8] = curOp.wdata[b*8 +: 8];
                end
                shDirty[set][way] = 1'b1;
            end
            lastFail = exp.fail;
            resultsSeen++;
        end
    end

    // a failed op must start the predicted request, then the handler drains
    task automatic checkMiss();
        int waited;
        waited = 0;
        while (reqLog.size() == 0) begin
            if (waited == 2)
                failRun("no memory request within two cycles of a failed result");
            @(negedge clk);
            waited++;
        end
        checkMemReq(testName, expMiss, reqLog.pop_front());
        while (busy !== 1'b0) begin
            if (stall !== 1'b1)
                failRun("stall was low while the miss handler was busy");
            @(negedge clk);
        end
    endtask

    // one op, retried until it completes without fail
    task automatic doOp(input logic isStore, input logic [31:0] addr,
                        input logic [31:0] wdata, input logic [3:0] wmask);
        lsuOp_t o;
        int n;
        o = '0;
        o.valid = 1'b1;
        o.isStore = isStore;
        o.addr.raw = addr;
        o.wdata = wdata;
        o.wmask = wmask;
        do begin
            @(posedge clk);
            op <= o;
            curOp = o;
            @(negedge clk);
            while (stall !== 1'b0)
                @(negedge clk);
            // accepted on this edge
            @(posedge clk);
            op <= '0;
            n = resultsSeen;
            @(negedge clk);
            @(negedge clk);
            if (result.valid !== 1'b0)
                failRun("result.valid came before the second edge after acceptance");
            @(negedge clk);
            if (result.valid !== 1'b1)
                failRun("result.valid did not follow the acceptance by two edges");
            wait (resultsSeen == n + 1);
            if (lastFail)
                checkMiss();
        end while (lastFail);
    endtask

    // write-backs must match the dirty shadow lines in walk order
    task automatic doFlush();
        memReq_t exp;
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        @(negedge clk);
        if (busy !== 1'b1)
            failRun("busy did not rise after a flush request");
        while (busy !== 1'b0)
            @(negedge clk);
        for (int s = 0; s < numSets; s++) begin
            for (int w = 0; w < numWays; w++) begin
                if (shValid[s][w] && shDirty[s][w]) begin
                    exp.cmd = MEMC_WRITEBACK;
                    exp.readAddr = '0;
                    exp.writeAddr = shAddr[s][w];
                    exp.wline = refLine(shAddr[s][w]);
                    if (reqLog.size() == 0)
                        failRun("the flush wrote back fewer lines than were dirty");
                    checkMemReq(testName, exp, reqLog.pop_front());
                end
                shValid[s][w] = 1'b0;
                shDirty[s][w] = 1'b0;
            end
        end
        if (reqLog.size() != 0)
            failRun("the flush wrote back a line that was not dirty");
    endtask

    initial begin : mainSeq
        logic [31:0] a0;
        int unsigned seedVal;
        seedVal = $urandom(32'h1ab0);
        rst = 1'b1;
        op = '0;
        flush = 1'b0;
        ack = 1'b0;
        rline = '0;
        curOp = '0;
        lastFail = 1'b0;
        victimCnt = 0;
        resultsSeen = 0;
        testName = "reset";
        for (int i = 0; i < memSize; i++) begin
            memWords[i] = fillWord(i);
            refMem[i] = fillWord(i);
        end
        for (int s = 0; s < numSets; s++) begin
            for (int w = 0; w < numWays; w++) begin
                shAddr[s][w] = '0;
                shValid[s][w] = 1'b0;
                shDirty[s][w] = 1'b0;
            end
        end

        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        if (busy !== 1'b1)
            failRun("busy is low during the initial invalidation");
        if (req !== 1'b0 || result.valid !== 1'b0 || memReq.cmd !== MEMC_NONE)
            failRun("req, result.valid or memReq.cmd is active after reset");
        while (busy !== 1'b0) begin
            if (req !== 1'b0)
                failRun("a memory request appeared during the initial invalidation");
            if (stall !== 1'b1)
                failRun("stall is low during the initial invalidation");
            @(negedge clk);
        end

        testName = "first load";
        a0 = 32'h0000_0124;
        doOp(1'b0, a0, 32'h0, 4'h0);

        testName = "random loads";
        for (int i = 0; i < 8; i++)
            doOp(1'b0, $urandom_range(255, 0) * 4, 32'h0, 4'h0);

        testName = "masked store";
        doOp(1'b0, a0, 32'h0, 4'h0);
        doOp(1'b1, a0, $urandom(), 4'($urandom_range(15, 1)));
        doOp(1'b0, a0, 32'h0, 4'h0);
        doOp(1'b0, a0 ^ 32'h4, 32'h0, 4'h0);

        // three more lines of the same set push out both ways
        testName = "eviction";
        doOp(1'b1, a0, $urandom(), 4'hf);
        for (int i = 1; i <= 3; i++)
            doOp(1'b0, a0 + i * 128, 32'h0, 4'h0);

        testName = "flush";
        for (int i = 0; i < 4; i++)
            doOp(1'b1, $urandom_range(255, 0) * 4, $urandom(), 4'($urandom_range(15, 1)));
        doFlush();
        testName = "load after flush";
        doOp(1'b0, a0 + 384, 32'h0, 4'h0);

        if (dut0.hsCheck0.errCount != 0) begin
            failRun("handshake assertions failed during the run");
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* lsuHandshake_assert.sv */
// handshake and reset checks for the load/store unit, bound into the top level
`timescale 1ns/1ns
`default_nettype none

module lsuHandshake_assert (
    input wire logic clk,
    input wire logic rst,
    input wire lsuPkg::memReq_t memReq,
    input wire logic req,
    input wire logic ack,
    input wire lsuPkg::lsuResult_t result
);
    int errCount = 0;

    // request payload holds until the controller answers
    reqStable: assert property (@(posedge clk) disable iff (rst)
        req && !ack |=> $stable(memReq))
        else begin
            errCount++;
            $error("memReq changed while req waited for ack");
        end

    // a new request waits for the previous ack to fall
    reqAfterAck: assert property (@(posedge clk) disable iff (rst) $rose(req) |-> !ack)
        else begin
            errCount++;
            $error("req rose while ack was still high");
        end

    resultInReset: assert property (@(posedge clk) rst |=> !result.valid)
        else begin
            errCount++;
            $error("result.valid was high during reset");
        end

endmodule

bind loadStoreUnit lsuHandshake_assert hsCheck0 (
    .clk(clk), .rst(rst), .memReq(memReq), .req(req), .ack(ack),
    .result(result)
);

`default_nettype wire

/* loadStoreUnit.sv */
// load/store unit top with a 2-way set-associative data cache and blocking misses
`timescale 1ns/1ns
`default_nettype none

module loadStoreUnit (
    input wire logic clk,
    input wire logic rst,

    input wire lsuPkg::lsuOp_t op,
    output logic stall,
    output lsuPkg::lsuResult_t result,

    input wire logic flush,
    output logic busy,

    output lsuPkg::memReq_t memReq,
    output logic req,
    input wire logic ack,
    input wire lsuPkg::lineData_t rline
);
    import lsuPkg::*;

    logic [indexBits-1:0] rdIndex;
    logic [indexBits-1:0] walkIndex;
    logic [numWays-1:0] rdValid;
    logic [numWays-1:0][tagBits-1:0] rdTag;
    lineData_t [numWays-1:0] rdLine;

    logic stWe;
    logic [indexBits-1:0] stIndex;
    wayIdx_t stWay;
    logic [$clog2(lineWords)-1:0] stWord;
    logic [31:0] stData;
    logic [3:0] stMask;

    logic tagWe;
    logic [indexBits-1:0] tagIndex;
    wayIdx_t tagWay;
    logic [tagBits-1:0] tagTag;
    logic tagValid;

    logic fillWe;
    logic [indexBits-1:0] fillIndex;
    wayIdx_t fillWay;
    lineData_t fillLine;

    missInfo_t pipeMiss;
    wayIdx_t victimWay;
    logic hold;
    logic pipeEmpty;

    cacheTagTable tagTable0 (
        .clk(clk), .rst(rst),
        .rdIndex(rdIndex), .rdValid(rdValid), .rdTag(rdTag),
        .we(tagWe), .wrIndex(tagIndex), .wrWay(tagWay), .wrTag(tagTag), .wrValid(tagValid)
    );

    cacheDataArray dataArray0 (
        .clk(clk),
        .rdIndex(rdIndex), .rdLine(rdLine),
        .stWe(stWe), .stIndex(stIndex), .stWay(stWay), .stWord(stWord),
        .stData(stData), .stMask(stMask),
        .fillWe(fillWe), .fillIndex(fillIndex), .fillWay(fillWay), .fillLine(fillLine)
    );

    lsuPipeline pipe0 (
        .clk(clk), .rst(rst),
        .op(op), .hold(hold), .stall(stall), .result(result), .empty(pipeEmpty),
        .rdIndex(rdIndex), .walkIndex(walkIndex),
        .rdValid(rdValid), .rdTag(rdTag), .rdLine(rdLine),
        .stWe(stWe), .stIndex(stIndex), .stWay(stWay), .stWord(stWord),
        .stData(stData), .stMask(stMask),
        .miss(pipeMiss), .victimWay(victimWay)
    );

    missHandler missHandler0 (
        .clk(clk), .rst(rst), .flush(flush),
        .miss(pipeMiss), .storeHit(pipeMiss.hit), .storeHitWay(pipeMiss.way),
        .pipeEmpty(pipeEmpty),
        .tagWe(tagWe), .tagIndex(tagIndex), .tagWay(tagWay), .tagTag(tagTag),
        .tagValid(tagValid),
        .fillWe(fillWe), .fillIndex(fillIndex), .fillWay(fillWay), .fillLine(fillLine),
        .victimWay(victimWay), .hold(hold), .busy(busy),
        .walkIndex(walkIndex), .rdValid(rdValid), .rdTag(rdTag), .rdLine(rdLine),
        .memReq(memReq), .req(req), .ack(ack), .rline(rline)
    );

endmodule

`default_nettype wire

/* missHandler.sv */
// miss handler: victim choice, dirty bits, memory handshake, flush walk and invalidate
`timescale 1ns/1ns
`default_nettype none

module missHandler (
    input wire logic clk,
    input wire logic rst,
    input wire logic flush,

    input wire lsuPkg::missInfo_t miss,
    input wire logic storeHit,
    input wire lsuPkg::wayIdx_t storeHitWay,
    input wire logic pipeEmpty,

    output logic tagWe,
    output logic [lsuPkg::indexBits-1:0] tagIndex,
    output lsuPkg::wayIdx_t tagWay,
    output logic [lsuPkg::tagBits-1:0] tagTag,
    output logic tagValid,

    output logic fillWe,
    output logic [lsuPkg::indexBits-1:0] fillIndex,
    output lsuPkg::wayIdx_t fillWay,
    output lsuPkg::lineData_t fillLine,

    output lsuPkg::wayIdx_t victimWay,
    output logic hold,
    output logic busy,

    // victim and walk reads share the array read port
    output logic [lsuPkg::indexBits-1:0] walkIndex,
    input wire logic [lsuPkg::numWays-1:0] rdValid,
    input wire logic [lsuPkg::numWays-1:0][lsuPkg::tagBits-1:0] rdTag,
    input wire lsuPkg::lineData_t [lsuPkg::numWays-1:0] rdLine,

    output lsuPkg::memReq_t memReq,
    output logic req,
    input wire logic ack,
    input wire lsuPkg::lineData_t rline
);
    import lsuPkg::*;

    typedef enum logic [2:0] {
        IDLE,
        REQ,
        RELEASE,
        WALK_READ,
        WALK_CHECK,
        SWEEP
    } state_e;

    state_e state;
    logic flushQueued;
    logic [indexBits-1:0] cntSet;
    wayIdx_t cntWay;
    logic [numWays-1:0][numSets-1:0] dirty;
    wayIdx_t reqWay;
    logic [indexBits-1:0] reqSet;
    logic ackFill;
    cacheAddr_t fillAddr;

    assign fillAddr = memReq.readAddr;
    assign ackFill = state == REQ && ack && memReq.cmd != MEMC_WRITEBACK;

    // tag writes come from the fill or the invalidate sweep
    assign tagWe = ackFill || state == SWEEP;
    assign tagIndex = (state == SWEEP) ? cntSet : reqSet;
    assign tagWay = (state == SWEEP) ? cntWay : reqWay;
    assign tagTag = fillAddr.split.tag;
    assign tagValid = state != SWEEP;

    assign fillWe = ackFill;
    assign fillIndex = reqSet;
    assign fillWay = reqWay;
    assign fillLine = rline;

    assign busy = state != IDLE || flushQueued;
    assign hold = busy || flush;
    assign walkIndex = cntSet;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= SWEEP;
            flushQueued <= 1'b0;
            {cntSet, cntWay} <= '0;
            victimWay <= '0;
            dirty <= '0;
            req <= 1'b0;
            memReq.cmd <= MEMC_NONE;
        end else begin
            if (flush)
                flushQueued <= 1'b1;
            if (storeHit)
                dirty[storeHitWay][miss.addr.split.index] <= 1'b1;

            case (state)
                IDLE: begin
                    if (miss.valid) begin
                        victimWay <= victimWay + 1'b1;
                        reqWay <= miss.way;
                        reqSet <= miss.addr.split.index;
                        // only a dirty valid victim goes back to memory
                        if (rdValid[miss.way] && dirty[miss.way][miss.addr.split.index])
                            memReq.cmd <= MEMC_REPLACE;
                        else
                            memReq.cmd <= MEMC_FILL;
                        memReq.readAddr <= {miss.addr.raw[31:offsetBits], {offsetBits{1'b0}}};
                        memReq.writeAddr <= {rdTag[miss.way], miss.addr.split.index,
                                             {offsetBits{1'b0}}};
                        memReq.wline <= rdLine[miss.way];
                        req <= 1'b1;
                        state <= REQ;
                    end else if (flushQueued && pipeEmpty) begin
                        flushQueued <= 1'b0;
                        {cntSet, cntWay} <= '0;
                        state <= WALK_READ;
                    end
                end
                WALK_READ: begin
                    state <= WALK_CHECK;
                end
                WALK_CHECK: begin
                    if (rdValid[cntWay] && dirty[cntWay][cntSet]) begin
                        memReq.cmd <= MEMC_WRITEBACK;
                        memReq.readAddr <= '0;
                        memReq.writeAddr <= {rdTag[cntWay], cntSet, {offsetBits{1'b0}}};
                        memReq.wline <= rdLine[cntWay];
                        reqWay <= cntWay;
                        reqSet <= cntSet;
                        req <= 1'b1;
                        state <= REQ;
                    end else begin
                        {cntSet, cntWay} <= {cntSet, cntWay} + 1'b1;
                        if (&{cntSet, cntWay})
                            state <= SWEEP;
                        else if (cntWay == wayIdx_t'(numWays - 1))
                            state <= WALK_READ;
                    end
                end
                REQ: begin
                    if (ack) begin
                        req <= 1'b0;
                        dirty[reqWay][reqSet] <= 1'b0;
                        state <= RELEASE;
                    end
                end
                RELEASE: begin
                    // the walk rechecks the same way, which is clean by now
                    if (!ack) begin
                        memReq.cmd <= MEMC_NONE;
                        state <= (memReq.cmd == MEMC_WRITEBACK) ? WALK_CHECK : IDLE;
                    end
                end
                SWEEP: begin
                    dirty[cntWay][cntSet] <= 1'b0;
                    {cntSet, cntWay} <= {cntSet, cntWay} + 1'b1;
                    if (&{cntSet, cntWay})
                        state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* lsuPipeline.sv */
// two-stage op pipeline: accept and read, then tag compare, hit merge and fail report
`timescale 1ns/1ns
`default_nettype none

module lsuPipeline (
    input wire logic clk,
    input wire logic rst,

    input wire lsuPkg::lsuOp_t op,
    input wire logic hold,
    output logic stall,
    output lsuPkg::lsuResult_t result,
    output logic empty,

    // read side of both arrays
    output logic [lsuPkg::indexBits-1:0] rdIndex,
    input wire logic [lsuPkg::indexBits-1:0] walkIndex,
    input wire logic [lsuPkg::numWays-1:0] rdValid,
    input wire logic [lsuPkg::numWays-1:0][lsuPkg::tagBits-1:0] rdTag,
    input wire lsuPkg::lineData_t [lsuPkg::numWays-1:0] rdLine,

    // store write into the data array
    output logic stWe,
    output logic [lsuPkg::indexBits-1:0] stIndex,
    output lsuPkg::wayIdx_t stWay,
    output logic [$clog2(lsuPkg::lineWords)-1:0] stWord,
    output logic [31:0] stData,
    output logic [3:0] stMask,

    output lsuPkg::missInfo_t miss,
    input wire lsuPkg::wayIdx_t victimWay
);
    import lsuPkg::*;

    lsuOp_t s0;
    lsuOp_t s1;
    lsuResult_t s1Result;
    logic hit;
    wayIdx_t hitWay;
    logic s1Miss;
    logic storeOk;
    logic [$clog2(lineWords)-1:0] wordSel;

    always_ff @(posedge clk) begin
        s0 <= op;
        s1 <= s0;
        result <= s1Result;
        if (rst) begin
            s0.valid <= 1'b0;
            s1.valid <= 1'b0;
            result.valid <= 1'b0;
        end else begin
            s0.valid <= op.valid && !stall;
        end
    end

    // the flush walk borrows the read port while the pipeline is idle
    assign rdIndex = s0.valid ? s0.addr.split.index : walkIndex;
    assign empty = !s0.valid && !s1.valid;

    // tag compare in stage 1
    always_comb begin
        hit = 1'b0;
        hitWay = '0;
        for (int w = 0; w < numWays; w++) begin
            if (rdValid[w] && rdTag[w] == s1.addr.split.tag) begin
                hit = 1'b1;
                hitWay = wayIdx_t'(w);
            end
        end
    end

    assign wordSel = s1.addr.raw[offsetBits-1:2];
    assign s1Miss = s1.valid && !hit;
    // stores wait out a busy miss handler, the victim line may be in flight
    assign storeOk = s1.valid && s1.isStore && hit && !hold;

    always_comb begin
        s1Result.valid = s1.valid;
        s1Result.fail = !hit || (s1.isStore && hold);
        s1Result.isStore = s1.isStore;
        s1Result.addr = s1.addr;
        if (s1.isStore)
            s1Result.data = s1.wdata;
        else
            s1Result.data = rdLine[hitWay][wordSel*32 +: 32];
    end

    assign stWe = storeOk;
    assign stIndex = s1.addr.split.index;
    assign stWay = hitWay;
    assign stWord = wordSel;
    assign stData = s1.wdata;
    assign stMask = s1.wmask;

    // a miss seen while the handler is busy only fails
    assign miss.valid = s1Miss && !hold;
    assign miss.hit = storeOk;
    assign miss.way = hit ? hitWay : victimWay;
    assign miss.addr = s1.addr;

    assign stall = hold || s1Miss;

endmodule

`default_nettype wire

/* cacheDataArray.sv */
// cache line storage with synchronous read, byte-masked store write and line fill
`timescale 1ns/1ns
`default_nettype none

module cacheDataArray (
    input wire logic clk,

    input wire logic [lsuPkg::indexBits-1:0] rdIndex,
    output lsuPkg::lineData_t [lsuPkg::numWays-1:0] rdLine,

    input wire logic stWe,
    input wire logic [lsuPkg::indexBits-1:0] stIndex,
    input wire lsuPkg::wayIdx_t stWay,
    input wire logic [$clog2(lsuPkg::lineWords)-1:0] stWord,
    input wire logic [31:0] stData,
    input wire logic [3:0] stMask,

    input wire logic fillWe,
    input wire logic [lsuPkg::indexBits-1:0] fillIndex,
    input wire lsuPkg::wayIdx_t fillWay,
    input wire lsuPkg::lineData_t fillLine
);
    import lsuPkg::*;

    lineData_t lines [numWays][numSets];
    lineData_t stLine;
    logic stDo;

    // stored line with the masked bytes merged in
    always_comb begin
        stLine = lines[stWay][stIndex];
        for (int b = 0; b < 4; b++) begin
            if (stMask[b])
                stLine[stWord*32 + b*8 +: 8] = stData[b*8 +: 8];
        end
    end

    assign stDo = stWe && !fillWe;

    always_ff @(posedge clk) begin
        if (fillWe)
            lines[fillWay][fillIndex] <= fillLine;
        else if (stWe)
            lines[stWay][stIndex] <= stLine;

        // a store to the line being read is forwarded, so a following load sees it
        for (int w = 0; w < numWays; w++) begin
            if (stDo && stWay == wayIdx_t'(w) && stIndex == rdIndex)
                rdLine[w] <= stLine;
            else
                rdLine[w] <= lines[w][rdIndex];
        end
    end

endmodule

`default_nettype wire

/* cacheTagTable.sv */
// tag table holding tag and valid per set and way, read one cycle after the index
`timescale 1ns/1ns
`default_nettype none

module cacheTagTable (
    input wire logic clk,
    input wire logic rst,

    input wire logic [lsuPkg::indexBits-1:0] rdIndex,
    output logic [lsuPkg::numWays-1:0] rdValid,
    output logic [lsuPkg::numWays-1:0][lsuPkg::tagBits-1:0] rdTag,

    input wire logic we,
    input wire logic [lsuPkg::indexBits-1:0] wrIndex,
    input wire lsuPkg::wayIdx_t wrWay,
    input wire logic [lsuPkg::tagBits-1:0] wrTag,
    input wire logic wrValid
);
    import lsuPkg::*;

    logic [tagBits-1:0] tags [numWays][numSets];
    logic [numSets-1:0] valids [numWays];

    // no writes land while reset is held
    always_ff @(posedge clk) begin
        if (we && !rst) begin
            tags[wrWay][wrIndex] <= wrTag;
            valids[wrWay][wrIndex] <= wrValid;
        end
    end

    // all ways are read in parallel for the compare
    always_ff @(posedge clk) begin
        for (int w = 0; w < numWays; w++) begin
            rdValid[w] <= valids[w][rdIndex];
            rdTag[w] <= tags[w][rdIndex];
        end
    end

endmodule

`default_nettype wire

/* lsuPkg.sv */
// load/store unit package: cache geometry, address views and the shared request structs
`default_nettype none

package lsuPkg;

    // cache geometry
    localparam int numWays = 2;
    localparam int numSets = 8;
    localparam int lineWords = 4;
    localparam int offsetBits = 4;
    localparam int indexBits = 3;
    localparam int tagBits = 25;

    typedef struct packed {
        logic [tagBits-1:0] tag;
        logic [indexBits-1:0] index;
        logic [offsetBits-1:0] offset;
    } addrSplit_t;

    // the same address word seen as a plain byte address or as tag/index/offset
    typedef union packed {
        logic [31:0] raw;
        addrSplit_t split;
    } cacheAddr_t;

    typedef logic [lineWords*32-1:0] lineData_t;
    typedef logic [$clog2(numWays)-1:0] wayIdx_t;

    // core request
    typedef struct packed {
        logic valid;
        logic isStore;
        cacheAddr_t addr;
        logic [31:0] wdata;
        logic [3:0] wmask;
        logic pad;
    } lsuOp_t;

    // fail means the op missed and has to be retried by the core
    typedef struct packed {
        logic valid;
        logic fail;
        logic isStore;
        cacheAddr_t addr;
        logic [31:0] data;
    } lsuResult_t;

    typedef enum logic [1:0] {
        MEMC_NONE,
        MEMC_FILL,
        MEMC_REPLACE,
        MEMC_WRITEBACK
    } memCmd_e;

    // one whole line per transfer
    typedef struct packed {
        memCmd_e cmd;
        logic [31:0] readAddr;
        logic [31:0] writeAddr;
        lineData_t wline;
    } memReq_t;

    // valid requests a miss, hit marks a store hit in way
    typedef struct packed {
        logic valid;
        logic hit;
        wayIdx_t way;
        cacheAddr_t addr;
    } missInfo_t;

endpackage

`default_nettype wire
